//--- Makefile
# Verilator build and run of the ID remapper testbench

TOP  := axi_id_remap_tb
SRCS := $(shell grep -v '^+' project.f)

.PHONY: run clean

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "All tests passed!"

obj_dir/V$(TOP): project.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f project.f --top-module $(TOP)

clean:
	rm -rf obj_dir

//--- project.f
rtl/axi_remap_pkg.sv
rtl/axi_find_first_one.sv
rtl/axi_id_match.sv
rtl/axi_id_table.sv
rtl/axi_id_remap.sv
testbench/axi_id_remap_assert.sv
testbench/axi_id_remap_tb.sv

//--- rtl/axi_find_first_one.sv
// Binary tree that finds the lowest set bit of a vector and flags an empty vector
`timescale 1ns/1ps

module axi_find_first_one #(
  // Width of the searched vector, at least two
  parameter int WIDTH = 2
) (
  input  logic [WIDTH-1:0]         in_i,
  output logic [$clog2(WIDTH)-1:0] first_one_o,
  output logic                     no_ones_o
);

  // Depth of the tree, one level per index bit
  localparam int NUM_LEVELS = $clog2(WIDTH);
  localparam int NUM_NODES  = 2**NUM_LEVELS - 1;

  // Leaf index values, so the tree just passes indices upwards
  logic [WIDTH-1:0][NUM_LEVELS-1:0]     index_lut;
  // Per node, whether any bit below it is set
  logic [NUM_NODES-1:0]                 sel_nodes;
  // Per node, the lowest set index below it
  logic [NUM_NODES-1:0][NUM_LEVELS-1:0] index_nodes;

  for (genvar j = 0; j < WIDTH; j++) begin : gen_lut
    assign index_lut[j] = NUM_LEVELS'(j);
  end

  for (genvar level = 0; level < NUM_LEVELS; level++) begin : gen_level
    if (level < NUM_LEVELS - 1) begin : gen_inner
      // Inner nodes prefer the left child, which covers the lower indices
      for (genvar n = 0; n < 2**level; n++) begin : gen_node
        assign sel_nodes[2**level-1+n] =
          sel_nodes[2**(level+1)-1+2*n] | sel_nodes[2**(level+1)-1+2*n+1];
        assign index_nodes[2**level-1+n] = sel_nodes[2**(level+1)-1+2*n] ?
          index_nodes[2**(level+1)-1+2*n] : index_nodes[2**(level+1)-1+2*n+1];
      end
    end else begin : gen_leaves
      // Leaf nodes look at a pair of input bits each
      for (genvar k = 0; k < 2**level; k++) begin : gen_leaf
        if (2*k + 1 < WIDTH) begin : gen_pair
          assign sel_nodes[2**level-1+k]   = in_i[2*k] | in_i[2*k+1];
          assign index_nodes[2**level-1+k] = in_i[2*k] ? index_lut[2*k] : index_lut[2*k+1];
        end else if (2*k < WIDTH) begin : gen_single
          // Odd width leaves a leaf with only one real bit
          assign sel_nodes[2**level-1+k]   = in_i[2*k];
          assign index_nodes[2**level-1+k] = index_lut[2*k];
        end else begin : gen_unused
          // Beyond the vector, tied inactive so they never win
          assign sel_nodes[2**level-1+k]   = 1'b0;
          assign index_nodes[2**level-1+k] = '0;
        end
      end
    end
  end

  // The root node holds the answer for the whole vector
  assign first_one_o = index_nodes[0];
  assign no_ones_o   = ~sel_nodes[0];

endmodule

//--- rtl/axi_id_match.sv
// Comparator bank that locates the occupied slot holding a requested original ID
`timescale 1ns/1ps

module axi_id_match (
  input  axi_remap_pkg::remap_req_t                            req_i,
  input  axi_remap_pkg::slot_mask_t                            occupied_i,
  input  axi_remap_pkg::in_id_t [axi_remap_pkg::NUM_SLOTS-1:0] slot_ids_i,
  output axi_remap_pkg::match_res_t                            match_o
);

  import axi_remap_pkg::*;

  // One bit per slot that is in use and stores the requested ID
  slot_mask_t match_vec;
  slot_idx_t  match_slot;
  logic       no_match;

  // Free slots keep stale IDs, so occupancy has to qualify each compare
  always_comb begin
    for (int s = 0; s < NUM_SLOTS; s++) begin
      match_vec[s] = occupied_i[s] && (slot_ids_i[s] == req_i.id);
    end
  end

  // The table never stores one ID twice, so at most one bit is set here
  axi_find_first_one #(
    .WIDTH       (NUM_SLOTS)
  ) i_match_ffo (
    .in_i        (match_vec),
    .first_one_o (match_slot),
    .no_ones_o   (no_match)
  );

  assign match_o.slot = match_slot;
  // Any set bit means the ID already owns a slot
  assign match_o.hit  = ~no_match;

endmodule

//--- rtl/axi_id_remap.sv
// Top level of the ID remapper connecting the match unit and the slot table
`timescale 1ns/1ps

module axi_id_remap (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      alloc_i,
  input  axi_remap_pkg::remap_req_t alloc_req_i,
  input  logic                      free_i,
  input  axi_remap_pkg::slot_idx_t  free_slot_i,
  output logic                      alloc_done_o,
  output axi_remap_pkg::alloc_res_t alloc_res_o,
  output logic                      free_done_o,
  output axi_remap_pkg::in_id_t     free_id_o,
  output logic                      full_o
);

  import axi_remap_pkg::*;

  // Table contents fed back to the comparators
  slot_mask_t                occupied;
  in_id_t    [NUM_SLOTS-1:0] slot_ids;
  // Comparator result handed to the table in the same cycle
  match_res_t                match;

  axi_id_match i_id_match (
    .req_i      (alloc_req_i),
    .occupied_i (occupied),
    .slot_ids_i (slot_ids),
    .match_o    (match)
  );

  // The table owns all state and registers both responses
  axi_id_table i_id_table (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .alloc_i      (alloc_i),
    .alloc_req_i  (alloc_req_i),
    .match_i      (match),
    .free_i       (free_i),
    .free_slot_i  (free_slot_i),
    .occupied_o   (occupied),
    .slot_ids_o   (slot_ids),
    .alloc_done_o (alloc_done_o),
    .alloc_res_o  (alloc_res_o),
    .free_done_o  (free_done_o),
    .free_id_o    (free_id_o),
    .full_o       (full_o)
  );

endmodule

//--- rtl/axi_id_table.sv
// Slot table with stored IDs, outstanding counters, allocation decision and registered results
`timescale 1ns/1ps

module axi_id_table (
  input  logic                                                 clk_i,
  input  logic                                                 arst_n_i,
  input  logic                                                 alloc_i,
  input  axi_remap_pkg::remap_req_t                            alloc_req_i,
  input  axi_remap_pkg::match_res_t                            match_i,
  input  logic                                                 free_i,
  input  axi_remap_pkg::slot_idx_t                             free_slot_i,
  output axi_remap_pkg::slot_mask_t                            occupied_o,
  output axi_remap_pkg::in_id_t [axi_remap_pkg::NUM_SLOTS-1:0] slot_ids_o,
  output logic                                                 alloc_done_o,
  output axi_remap_pkg::alloc_res_t                            alloc_res_o,
  output logic                                                 free_done_o,
  output axi_remap_pkg::in_id_t                                free_id_o,
  output logic                                                 full_o
);

  import axi_remap_pkg::*;

  // Per slot state, a slot is in use while its counter is nonzero
  slot_cnt_t [NUM_SLOTS-1:0] cnt_q, cnt_d;
  in_id_t    [NUM_SLOTS-1:0] ids_q;
  slot_mask_t                occupied;

  // Lowest free slot, used when the ID is not in the table yet
  slot_idx_t free_slot;
  logic      no_free;

  // Allocation and release decision
  logic       hit_sat;
  logic       alloc_rej;
  logic       alloc_ok;
  logic       free_ok;
  slot_idx_t  alloc_slot;
  alloc_res_t alloc_res_d;
  slot_mask_t inc_mask;
  slot_mask_t dec_mask;

  // Result registers
  logic       alloc_done_q;
  logic       free_done_q;
  alloc_res_t alloc_res_q;
  in_id_t     free_id_q;

  always_comb begin
    for (int s = 0; s < NUM_SLOTS; s++) begin
      occupied[s] = (cnt_q[s] != '0);
    end
  end

  axi_find_first_one #(
    .WIDTH       (NUM_SLOTS)
  ) i_free_ffo (
    .in_i        (~occupied),
    .first_one_o (free_slot),
    .no_ones_o   (no_free)
  );

  // A hit reuses its slot to keep same-ID ordering, unless that slot is saturated
  assign hit_sat    = (cnt_q[match_i.slot] == CNT_MAX);
  assign alloc_rej  = match_i.hit ? hit_sat : no_free;
  assign alloc_slot = match_i.hit ? match_i.slot : free_slot;
  assign alloc_ok   = alloc_i & ~alloc_rej;
  // Releasing an empty slot is dropped without a response
  assign free_ok    = free_i & occupied[free_slot_i];

  assign alloc_res_d.slot     = alloc_rej ? '0 : alloc_slot;
  assign alloc_res_d.rejected = alloc_rej;

  // Both strobes act on the state from before this edge
  always_comb begin
    inc_mask = '0;
    dec_mask = '0;
    if (alloc_ok) inc_mask[alloc_slot] = 1'b1;
    if (free_ok) dec_mask[free_slot_i] = 1'b1;
  end

  always_comb begin
    cnt_d = cnt_q;
    for (int s = 0; s < NUM_SLOTS; s++) begin
      // Increment and decrement on the same slot cancel out
      case ({inc_mask[s], dec_mask[s]})
        2'b10:   cnt_d[s] = cnt_q[s] + 1'b1;
        2'b01:   cnt_d[s] = cnt_q[s] - 1'b1;
        default: cnt_d[s] = cnt_q[s];
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q        <= '0;
      alloc_done_q <= 1'b0;
      free_done_q  <= 1'b0;
    end else begin
      cnt_q        <= cnt_d;
      alloc_done_q <= alloc_i;
      free_done_q  <= free_ok;
    end
  end

  // A hit writes back the same ID, so the write only matters on a miss
  always_ff @(posedge clk_i) begin
    if (alloc_ok) ids_q[alloc_slot] <= alloc_req_i.id;
    if (alloc_i) alloc_res_q <= alloc_res_d;
    if (free_ok) free_id_q <= ids_q[free_slot_i];
  end

  assign occupied_o   = occupied;
  assign slot_ids_o   = ids_q;
  assign alloc_done_o = alloc_done_q;
  assign alloc_res_o  = alloc_res_q;
  assign free_done_o  = free_done_q;
  assign free_id_o    = free_id_q;
  // Full comes straight from the counters, not from the result registers
  assign full_o       = no_free;

endmodule

//--- rtl/axi_remap_pkg.sv
// Remapper widths, slot count, vector typedefs and the request and result structs
package axi_remap_pkg;

  // Number of narrow slot IDs offered on the master side
  localparam int NUM_SLOTS      = 8;
  // Width of the original ID seen on the slave side
  localparam int IN_ID_WIDTH    = 6;
  localparam int SLOT_IDX_WIDTH = $clog2(NUM_SLOTS);
  // Each slot tracks up to three outstanding transactions
  localparam int CNT_WIDTH      = 2;

  typedef logic [IN_ID_WIDTH-1:0]    in_id_t;
  typedef logic [SLOT_IDX_WIDTH-1:0] slot_idx_t;
  typedef logic [CNT_WIDTH-1:0]      slot_cnt_t;
  typedef logic [NUM_SLOTS-1:0]      slot_mask_t;

  // Highest count a slot can reach before further requests are refused
  localparam slot_cnt_t CNT_MAX = '1;

  // An allocation request only carries the wide ID for now
  typedef struct packed {
    in_id_t id;
  } remap_req_t;

  // Registered outcome of an allocation, slot is zero when rejected
  typedef struct packed {
    slot_idx_t slot;
    logic      rejected;
  } alloc_res_t;

  // Slot that already holds the requested ID
  typedef struct packed {
    slot_idx_t slot;
    logic      hit;
  } match_res_t;

endpackage

//--- testbench/axi_id_remap_assert.sv
// Concurrent assertions on reset, response latency and full behavior of the ID remapper
`timescale 1ns/1ps

module axi_id_remap_assert (
  input logic                                                 clk_i,
  input logic                                                 arst_n_i,
  input logic                                                 alloc_i,
  input axi_remap_pkg::remap_req_t                            alloc_req_i,
  input logic                                                 free_i,
  input axi_remap_pkg::slot_idx_t                             free_slot_i,
  input axi_remap_pkg::slot_mask_t                            occupied_i,
  input axi_remap_pkg::in_id_t [axi_remap_pkg::NUM_SLOTS-1:0] slot_ids_i,
  input logic                                                 alloc_done_o,
  input axi_remap_pkg::alloc_res_t                            alloc_res_o,
  input logic                                                 free_done_o,
  input logic                                                 full_o
);

  import axi_remap_pkg::*;

  // Set when an occupied slot already stores the requested ID
  logic id_stored;

  always_comb begin
    id_stored = 1'b0;
    for (int s = 0; s < NUM_SLOTS; s++) begin
      if (occupied_i[s] && (slot_ids_i[s] == alloc_req_i.id)) id_stored = 1'b1;
    end
  end

  // Both responses stay quiet while reset is held
  assert property (@(posedge clk_i) !arst_n_i |-> !alloc_done_o && !free_done_o)
    else $error("done output high during reset");

  // Every allocation strobe is answered exactly one cycle later
  assert property (@(posedge clk_i) disable iff (!arst_n_i) alloc_i |=> alloc_done_o)
    else $error("alloc_done_o missing one cycle after alloc_i");
  assert property (@(posedge clk_i) disable iff (!arst_n_i) !alloc_i |=> !alloc_done_o)
    else $error("alloc_done_o high without a preceding alloc_i");

  // A release of an empty slot gets no response
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    free_i && occupied_i[free_slot_i] |=> free_done_o)
    else $error("free_done_o missing after a valid release");
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(free_i && occupied_i[free_slot_i]) |=> !free_done_o)
    else $error("free_done_o high without a valid release");

  // With no free slot a new ID can only be rejected
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    full_o && alloc_i && !id_stored |=> alloc_res_o.rejected)
    else $error("miss allocation accepted while full");

endmodule

bind axi_id_remap axi_id_remap_assert i_remap_assert (
  .clk_i        (clk_i),
  .arst_n_i     (arst_n_i),
  .alloc_i      (alloc_i),
  .alloc_req_i  (alloc_req_i),
  .free_i       (free_i),
  .free_slot_i  (free_slot_i),
  .occupied_i   (occupied),
  .slot_ids_i   (slot_ids),
  .alloc_done_o (alloc_done_o),
  .alloc_res_o  (alloc_res_o),
  .free_done_o  (free_done_o),
  .full_o       (full_o)
);

//--- testbench/axi_id_remap_tb.sv
// Testbench with clock, reset, row table, reference model, LFSR rows, checks and timeout
`timescale 1ns/1ps

module axi_id_remap_tb;

  import axi_remap_pkg::*;

  localparam int NUM_DIRECTED   = 18;
  localparam int NUM_RANDOM     = 24;
  localparam int NUM_ROWS       = NUM_DIRECTED + NUM_RANDOM;
  // Twice the two cycles a row needs, plus room for reset
  localparam int TIMEOUT_CYCLES = NUM_ROWS * 4 + 20;

  // Bit 0 asks for an allocation and bit 1 for a release
  localparam logic [1:0] KIND_ALLOC = 2'b01;
  localparam logic [1:0] KIND_FREE  = 2'b10;
  localparam logic [1:0] KIND_BOTH  = 2'b11;

  // One row of stimulus with the responses expected one cycle later
  typedef struct packed {
    logic [1:0] kind;
    in_id_t     id;
    slot_idx_t  slot;
    slot_idx_t  exp_slot;
    logic       exp_rej;
    in_id_t     exp_id;
    logic       exp_fdone;
    logic       exp_full;
  } row_t;

  logic        clk;
  logic        arst_n;
  logic        alloc_stb;
  remap_req_t  alloc_req;
  logic        free_stb;
  slot_idx_t   free_slot;
  logic        alloc_done;
  alloc_res_t  alloc_res;
  logic        free_done;
  in_id_t      free_id;
  logic        full;

  row_t        rows [NUM_ROWS];
  string       row_names [NUM_ROWS];
  int          row_cnt = 0;
  int          cycle_cnt = 0;
  logic [15:0] lfsr_state = 16'd25500;
  // Reference model of the slot table
  slot_cnt_t   model_cnt [NUM_SLOTS];
  in_id_t      model_id [NUM_SLOTS];

  axi_id_remap axi_id_remap_i (
    .clk_i        (clk),
    .arst_n_i     (arst_n),
    .alloc_i      (alloc_stb),
    .alloc_req_i  (alloc_req),
    .free_i       (free_stb),
    .free_slot_i  (free_slot),
    .alloc_done_o (alloc_done),
    .alloc_res_o  (alloc_res),
    .free_done_o  (free_done),
    .free_id_o    (free_id),
    .full_o       (full)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: the rows did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Test failures found");
      $fatal(1, "run stopped by timeout");
    end
  end

  task automatic check_value(input string name, input string field, input int expected,
                             input int actual);
    if (expected != actual) begin
      $display("mismatch %s %s: expected %0h, actual %0h", name, field, expected, actual);
      $display("Test failures found");
      $fatal(1, "run stopped at first error");
    end
  endtask

  // Galois form of x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    if (state[0]) return (state >> 1) ^ 16'hB400;
    return state >> 1;
  endfunction

  function automatic int rand_bits(input int n);
    int value;
    value = 0;
    for (int b = 0; b < n; b++) begin
      value = (value << 1) | int'(lfsr_state[0]);
      lfsr_state = lfsr_next(lfsr_state);
    end
    return value;
  endfunction

  task automatic add_row(input string name, input logic [1:0] kind, input in_id_t id,
                         input slot_idx_t slot, input slot_idx_t exp_slot, input logic exp_rej,
                         input in_id_t exp_id, input logic exp_fdone, input logic exp_full);
    row_names[row_cnt] = name;
    rows[row_cnt] = '{kind, id, slot, exp_slot, exp_rej, exp_id, exp_fdone, exp_full};
    row_cnt++;
  endtask

  // Predicts one row from the model state, then moves the model on
  task automatic model_row(input row_t stim, output row_t res);
    logic      hit;
    logic      no_free;
    logic      rej;
    logic      free_ok;
    slot_idx_t hit_slot;
    slot_idx_t low_free;
    slot_idx_t target;
    hit = 1'b0;
    no_free = 1'b1;
    hit_slot = '0;
    low_free = '0;
    // Walking down leaves the lowest free slot in low_free
    for (int s = NUM_SLOTS - 1; s >= 0; s--) begin
      if (model_cnt[s] == '0) begin
        no_free = 1'b0;
        low_free = slot_idx_t'(s);
      end else if (model_id[s] == stim.id) begin
        hit = 1'b1;
        hit_slot = slot_idx_t'(s);
      end
    end
    rej = hit ? (model_cnt[hit_slot] == slot_cnt_t'(3)) : no_free;
    target = hit ? hit_slot : low_free;
    free_ok = stim.kind[1] && (model_cnt[stim.slot] != '0);
    res = stim;
    res.exp_slot = (stim.kind[0] && !rej) ? target : '0;
    res.exp_rej = stim.kind[0] && rej;
    res.exp_fdone = free_ok;
    res.exp_id = free_ok ? model_id[stim.slot] : '0;
    if (stim.kind[0] && !rej) begin
      model_cnt[target] = model_cnt[target] + 2'd1;
      model_id[target] = stim.id;
    end
    if (free_ok) model_cnt[stim.slot] = model_cnt[stim.slot] - 2'd1;
    res.exp_full = 1'b1;
    for (int s = 0; s < NUM_SLOTS; s++) begin
      if (model_cnt[s] == '0) res.exp_full = 1'b0;
    end
  endtask

  task automatic check_result(input int r);
    row_t  want;
    string name;
    want = rows[r];
    name = row_names[r];
    check_value(name, "alloc_done", int'(want.kind[0]), int'(alloc_done));
    if (want.kind[0]) begin
      check_value(name, "slot", int'(want.exp_slot), int'(alloc_res.slot));
      check_value(name, "rejected", int'(want.exp_rej), int'(alloc_res.rejected));
    end
    check_value(name, "free_done", int'(want.exp_fdone), int'(free_done));
    if (want.exp_fdone) check_value(name, "free_id", int'(want.exp_id), int'(free_id));
    check_value(name, "full", int'(want.exp_full), int'(full));
  endtask

  initial begin
    row_t pred;
    clk = 1'b0;
    arst_n = 1'b1;
    alloc_stb = 1'b0;
    alloc_req = '0;
    free_stb = 1'b0;
    free_slot = '0;
    // Fill every slot, then overflow, saturate, release and collide strobes
    for (int i = 0; i < NUM_SLOTS; i++) begin
      add_row($sformatf("fill_%0d", i), KIND_ALLOC, in_id_t'(16 + i), 3'd0,
              slot_idx_t'(i), 1'b0, 6'h00, 1'b0, (i == NUM_SLOTS - 1));
    end
    add_row("reject_new",    KIND_ALLOC, 6'h20, 3'd0, 3'd0, 1'b1, 6'h00, 1'b0, 1'b1);
    add_row("reuse_1",       KIND_ALLOC, 6'h12, 3'd0, 3'd2, 1'b0, 6'h00, 1'b0, 1'b1);
    add_row("reuse_2",       KIND_ALLOC, 6'h12, 3'd0, 3'd2, 1'b0, 6'h00, 1'b0, 1'b1);
    add_row("reuse_sat",     KIND_ALLOC, 6'h12, 3'd0, 3'd0, 1'b1, 6'h00, 1'b0, 1'b1);
    add_row("release_5",     KIND_FREE,  6'h00, 3'd5, 3'd0, 1'b0, 6'h15, 1'b1, 1'b0);
    add_row("refill_5",      KIND_ALLOC, 6'h21, 3'd0, 3'd5, 1'b0, 6'h00, 1'b0, 1'b1);
    add_row("release_2",     KIND_FREE,  6'h00, 3'd2, 3'd0, 1'b0, 6'h12, 1'b1, 1'b1);
    add_row("both_full",     KIND_BOTH,  6'h22, 3'd0, 3'd0, 1'b1, 6'h10, 1'b1, 1'b0);
    add_row("release_empty", KIND_FREE,  6'h00, 3'd0, 3'd0, 1'b0, 6'h00, 1'b0, 1'b0);
    add_row("alloc_lowest",  KIND_ALLOC, 6'h23, 3'd0, 3'd0, 1'b0, 6'h00, 1'b0, 1'b1);
    // The model confirms the hand rows and fills in the random tail
    for (int s = 0; s < NUM_SLOTS; s++) begin
      model_cnt[s] = '0;
      model_id[s] = '0;
    end
    for (int r = 0; r < NUM_ROWS; r++) begin
      if (r < NUM_DIRECTED) begin
        model_row(rows[r], pred);
        check_value(row_names[r], "model row", int'(rows[r]), int'(pred));
      end else begin
        pred = '0;
        pred.kind = (rand_bits(2) < 2) ? KIND_ALLOC : KIND_FREE;
        pred.kind[0] = pred.kind[0] | (rand_bits(1) == 1);
        pred.id = in_id_t'(rand_bits(3));
        pred.slot = slot_idx_t'(rand_bits(3));
        model_row(pred, rows[r]);
        row_names[r] = $sformatf("random_%0d", r - NUM_DIRECTED);
      end
    end
    #1 arst_n = 1'b0;
    repeat (2) @(posedge clk);
    #1 arst_n = 1'b1;
    check_value("reset", "full", 0, int'(full));
    for (int r = 0; r < NUM_ROWS; r++) begin
      @(posedge clk);
      #1;
      alloc_stb = rows[r].kind[0];
      alloc_req.id = rows[r].id;
      free_stb = rows[r].kind[1];
      free_slot = rows[r].slot;
      @(posedge clk);
      #1;
      alloc_stb = 1'b0;
      free_stb = 1'b0;
      check_result(r);
    end
    $display("All tests passed!");
    $finish;
  end

endmodule
